// ==== src/icache_lookup.sv ====
module icache_lookup #(
    parameter int NUM_SETS = 128
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              fetch_valid_i,
    input  icache_pkg::addr_t fetch_pc_i,
    input  logic              fetch_uncache_i,
    input  logic              flush_i,
    input  logic              busy_i,
    output logic              req_valid_o,
    output icache_pkg::addr_t req_pc_o,
    output logic              req_uncache_o,
    icache_way_if.lookup      ways [icache_pkg::NUM_WAYS]
);

    localparam int INDEX_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS = 32 - icache_pkg::OFFSET_BITS - INDEX_BITS;

    logic                  accept;
    logic                  valid_q;
    logic                  uncache_q;
    icache_pkg::addr_t     pc_q;
    logic [INDEX_BITS-1:0] rd_index;

    assign accept = fetch_valid_i && !busy_i;

    // one compare cycle per accepted fetch
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept && !flush_i;
        end
    end

    // held for the controller while busy
    always_ff @(posedge clk) begin
        if (accept) begin
            pc_q <= fetch_pc_i;
            uncache_q <= fetch_uncache_i;
        end
    end

    // keep the ram pointed at the stalled fetch
    assign rd_index = busy_i ? pc_q[icache_pkg::OFFSET_BITS +: INDEX_BITS]
                             : fetch_pc_i[icache_pkg::OFFSET_BITS +: INDEX_BITS];

    for (genvar w = 0; w < icache_pkg::NUM_WAYS; w++) begin : g_way
        assign ways[w].rd_index = rd_index;
        assign ways[w].cmp_tag = pc_q[31 -: TAG_BITS];
    end

    assign req_valid_o = valid_q;
    assign req_pc_o = pc_q;
    assign req_uncache_o = uncache_q;

endmodule

// ==== src/icache_pkg.sv ====
package icache_pkg;

    // fetch address and instruction word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // line geometry
    localparam int WORDS_PER_LINE = 8;
    localparam int OFFSET_BITS = 5;

    // word k sits at bits 32k+31 down to 32k
    typedef logic [WORDS_PER_LINE*32-1:0] line_t;

    // one lru bit per set covers exactly two ways
    localparam int NUM_WAYS = 2;

endpackage

// ==== src/icache_refill_ctrl.sv ====
module icache_refill_ctrl #(
    parameter int NUM_SETS = 128
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid_i,
    input  icache_pkg::addr_t req_pc_i,
    input  logic              req_uncache_i,
    input  logic              flush_i,
    input  logic              cacop_i,
    input  icache_pkg::addr_t cacop_addr_i,
    output logic              busy_o,
    icache_way_if.ctrl        ways [icache_pkg::NUM_WAYS],
    output logic              mem_rd_req_o,
    output icache_pkg::addr_t mem_rd_addr_o,
    input  logic              mem_ret_valid_i,
    input  icache_pkg::line_t mem_ret_data_i,
    output logic              uc_ren_o,
    output icache_pkg::addr_t uc_addr_o,
    input  logic              uc_rvalid_i,
    input  icache_pkg::word_t uc_rdata_i,
    output logic              inst_valid_o,
    output icache_pkg::word_t inst_o,
    output icache_pkg::addr_t inst_pc_o
);

    localparam int INDEX_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS = 32 - icache_pkg::OFFSET_BITS - INDEX_BITS;
    localparam int WSEL_BITS = $clog2(icache_pkg::WORDS_PER_LINE);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MISS_WAIT,
        ST_UC_WAIT,
        ST_SETTLE
    } state_t;

    state_t                  state_q;
    logic [NUM_SETS-1:0]     lru_q;
    logic                    sweep_q;
    logic [INDEX_BITS-1:0]   sweep_idx_q;
    logic                    cacop_busy_q;
    logic                    cancel_q;
    logic                    mem_rd_req_q;
    logic                    uc_ren_q;
    logic                    inst_valid_q;
    icache_pkg::word_t       inst_q;
    icache_pkg::addr_t       inst_pc_q;

    logic [INDEX_BITS-1:0]   req_index;
    logic [INDEX_BITS-1:0]   cacop_index;
    logic [INDEX_BITS-1:0]   wr_index;
    logic [WSEL_BITS-1:0]    word_sel;
    logic [icache_pkg::NUM_WAYS-1:0] hit_vec;
    icache_pkg::line_t       rd_lines [icache_pkg::NUM_WAYS];
    icache_pkg::line_t       hit_line;
    logic                    hit_any;
    logic                    hit_way;
    logic                    victim;
    logic                    lookup_hit;
    logic                    start_miss;
    logic                    start_uc;
    logic                    cacop_accept;
    logic                    refill_done;
    logic                    uc_done;

    assign req_index = req_pc_i[icache_pkg::OFFSET_BITS +: INDEX_BITS];
    assign cacop_index = cacop_addr_i[icache_pkg::OFFSET_BITS +: INDEX_BITS];
    assign word_sel = req_pc_i[icache_pkg::OFFSET_BITS-1:2];

    for (genvar w = 0; w < icache_pkg::NUM_WAYS; w++) begin : g_way
        assign hit_vec[w] = ways[w].hit;
        assign rd_lines[w] = ways[w].rd_line;
        assign ways[w].wr_en = sweep_q || cacop_accept || (refill_done && victim == 1'(w));
        assign ways[w].wr_index = wr_index;
        assign ways[w].wr_valid = refill_done;
        assign ways[w].wr_tag = req_pc_i[31 -: TAG_BITS];
        assign ways[w].wr_line = mem_ret_data_i;
    end

    assign hit_any = |hit_vec;
    assign hit_way = hit_vec[1];
    assign hit_line = hit_way ? rd_lines[1] : rd_lines[0];
    // lru bit names the next victim
    assign victim = lru_q[req_index];

    assign lookup_hit = req_valid_i && !req_uncache_i && hit_any;
    assign start_miss = req_valid_i && !req_uncache_i && !hit_any;
    assign start_uc = req_valid_i && req_uncache_i;
    assign refill_done = (state_q == ST_MISS_WAIT) && mem_ret_valid_i;
    assign uc_done = (state_q == ST_UC_WAIT) && uc_rvalid_i;

    // a failed compare stalls in the same cycle
    assign busy_o = sweep_q || cacop_busy_q || (state_q != ST_IDLE) || start_miss || start_uc;
    assign cacop_accept = cacop_i && !busy_o;

    assign wr_index = sweep_q      ? sweep_idx_q :
                      cacop_accept ? cacop_index : req_index;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_IDLE;
            cancel_q <= 1'b0;
            mem_rd_req_q <= 1'b0;
            uc_ren_q <= 1'b0;
            cacop_busy_q <= 1'b0;
            sweep_q <= 1'b1;
            sweep_idx_q <= '0;
        end else begin
            mem_rd_req_q <= 1'b0;
            uc_ren_q <= 1'b0;
            cacop_busy_q <= cacop_accept;
            // clear every valid bit after reset
            if (sweep_q) begin
                sweep_idx_q <= sweep_idx_q + 1'b1;
                if (sweep_idx_q == INDEX_BITS'(NUM_SETS - 1)) begin
                    sweep_q <= 1'b0;
                end
            end
            case (state_q)
                ST_IDLE: begin
                    cancel_q <= flush_i;
                    if (start_miss) begin
                        state_q <= ST_MISS_WAIT;
                        mem_rd_req_q <= 1'b1;
                    end else if (start_uc) begin
                        state_q <= ST_UC_WAIT;
                        uc_ren_q <= 1'b1;
                    end
                end
                ST_MISS_WAIT: begin
                    cancel_q <= cancel_q || flush_i;
                    if (mem_ret_valid_i) begin
                        state_q <= ST_SETTLE;
                    end
                end
                ST_UC_WAIT: begin
                    cancel_q <= cancel_q || flush_i;
                    if (uc_rvalid_i) begin
                        state_q <= ST_SETTLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
        end else if (lookup_hit) begin
            lru_q[req_index] <= ~hit_way;
        end else if (refill_done) begin
            lru_q[req_index] <= ~victim;
        end
    end

    // flush drops delivery, never the refill itself
    always_ff @(posedge clk) begin
        if (reset) begin
            inst_valid_q <= 1'b0;
        end else begin
            inst_valid_q <= !flush_i
                && (lookup_hit || ((refill_done || uc_done) && !cancel_q));
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_hit) begin
            inst_q <= hit_line[32*word_sel +: 32];
        end else if (refill_done) begin
            inst_q <= mem_ret_data_i[32*word_sel +: 32];
        end else if (uc_done) begin
            inst_q <= uc_rdata_i;
        end
        if (lookup_hit || refill_done || uc_done) begin
            inst_pc_q <= req_pc_i;
        end
    end

    assign mem_rd_req_o = mem_rd_req_q;
    assign mem_rd_addr_o = {req_pc_i[31:icache_pkg::OFFSET_BITS], {icache_pkg::OFFSET_BITS{1'b0}}};
    assign uc_ren_o = uc_ren_q;
    assign uc_addr_o = req_pc_i;
    assign inst_valid_o = inst_valid_q;
    assign inst_o = inst_q;
    assign inst_pc_o = inst_pc_q;

    a_single_hit: assert property (
        @(posedge clk) disable iff (reset) req_valid_i |-> !(&hit_vec)
    );

    a_mem_ret_in_wait: assert property (
        @(posedge clk) disable iff (reset) mem_ret_valid_i |-> state_q == ST_MISS_WAIT
    );

    a_uc_ret_in_wait: assert property (
        @(posedge clk) disable iff (reset) uc_rvalid_i |-> state_q == ST_UC_WAIT
    );

endmodule

// ==== src/icache_sdp_ram.sv ====
module icache_sdp_ram #(
    parameter type payload_t = logic [31:0],
    parameter int  NUM_SETS  = 128
) (
    input  logic                        clk,
    input  logic                        wr_en_i,
    input  logic [$clog2(NUM_SETS)-1:0] wr_addr_i,
    input  payload_t                    wr_data_i,
    input  logic [$clog2(NUM_SETS)-1:0] rd_addr_i,
    output payload_t                    rd_data_o
);

    payload_t mem [NUM_SETS];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read, old data on a colliding write
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

// ==== src/icache_top.sv ====
module icache_top #(
    parameter int NUM_SETS = 128
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              fetch_valid_i,
    input  icache_pkg::addr_t fetch_pc_i,
    input  logic              fetch_uncache_i,
    input  logic              flush_i,
    input  logic              cacop_i,
    input  icache_pkg::addr_t cacop_addr_i,
    output logic              busy_o,
    output logic              inst_valid_o,
    output icache_pkg::word_t inst_o,
    output icache_pkg::addr_t inst_pc_o,
    output logic              mem_rd_req_o,
    output icache_pkg::addr_t mem_rd_addr_o,
    input  logic              mem_ret_valid_i,
    input  icache_pkg::line_t mem_ret_data_i,
    output logic              uc_ren_o,
    output icache_pkg::addr_t uc_addr_o,
    input  logic              uc_rvalid_i,
    input  icache_pkg::word_t uc_rdata_i
);

    logic              req_valid;
    icache_pkg::addr_t req_pc;
    logic              req_uncache;

    icache_way_if #(.NUM_SETS(NUM_SETS)) way_bus [icache_pkg::NUM_WAYS] ();

    icache_lookup #(
        .NUM_SETS (NUM_SETS)
    ) u_lookup (
        .clk             (clk),
        .reset           (reset),
        .fetch_valid_i   (fetch_valid_i),
        .fetch_pc_i      (fetch_pc_i),
        .fetch_uncache_i (fetch_uncache_i),
        .flush_i         (flush_i),
        .busy_i          (busy_o),
        .req_valid_o     (req_valid),
        .req_pc_o        (req_pc),
        .req_uncache_o   (req_uncache),
        .ways            (way_bus)
    );

    for (genvar w = 0; w < icache_pkg::NUM_WAYS; w++) begin : g_way
        icache_way #(
            .NUM_SETS (NUM_SETS)
        ) u_way (
            .clk (clk),
            .way (way_bus[w])
        );
    end

    icache_refill_ctrl #(
        .NUM_SETS (NUM_SETS)
    ) u_ctrl (
        .clk             (clk),
        .reset           (reset),
        .req_valid_i     (req_valid),
        .req_pc_i        (req_pc),
        .req_uncache_i   (req_uncache),
        .flush_i         (flush_i),
        .cacop_i         (cacop_i),
        .cacop_addr_i    (cacop_addr_i),
        .busy_o          (busy_o),
        .ways            (way_bus),
        .mem_rd_req_o    (mem_rd_req_o),
        .mem_rd_addr_o   (mem_rd_addr_o),
        .mem_ret_valid_i (mem_ret_valid_i),
        .mem_ret_data_i  (mem_ret_data_i),
        .uc_ren_o        (uc_ren_o),
        .uc_addr_o       (uc_addr_o),
        .uc_rvalid_i     (uc_rvalid_i),
        .uc_rdata_i      (uc_rdata_i),
        .inst_valid_o    (inst_valid_o),
        .inst_o          (inst_o),
        .inst_pc_o       (inst_pc_o)
    );

endmodule

// ==== src/icache_way.sv ====
module icache_way #(
    parameter int NUM_SETS = 128
) (
    input logic        clk,
    icache_way_if.way  way
);

    localparam int INDEX_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS = 32 - icache_pkg::OFFSET_BITS - INDEX_BITS;

    typedef struct packed {
        logic                valid;
        logic [TAG_BITS-1:0] tag;
    } tag_entry_t;

    tag_entry_t tag_wr;
    tag_entry_t tag_rd;
    logic       line_wr_en;

    assign tag_wr.valid = way.wr_valid;
    assign tag_wr.tag = way.wr_tag;

    // invalidates only touch the tag entry
    assign line_wr_en = way.wr_en && way.wr_valid;

    icache_sdp_ram #(
        .payload_t (tag_entry_t),
        .NUM_SETS  (NUM_SETS)
    ) u_tag_ram (
        .clk       (clk),
        .wr_en_i   (way.wr_en),
        .wr_addr_i (way.wr_index),
        .wr_data_i (tag_wr),
        .rd_addr_i (way.rd_index),
        .rd_data_o (tag_rd)
    );

    icache_sdp_ram #(
        .payload_t (icache_pkg::line_t),
        .NUM_SETS  (NUM_SETS)
    ) u_line_ram (
        .clk       (clk),
        .wr_en_i   (line_wr_en),
        .wr_addr_i (way.wr_index),
        .wr_data_i (way.wr_line),
        .rd_addr_i (way.rd_index),
        .rd_data_o (way.rd_line)
    );

    assign way.hit = tag_rd.valid && (tag_rd.tag == way.cmp_tag);

    a_wr_index_range: assert property (
        @(posedge clk) way.wr_en |-> (int'(way.wr_index) < NUM_SETS)
    );

endmodule

// ==== src/icache_way_if.sv ====
interface icache_way_if #(
    parameter int NUM_SETS = 128
);

    localparam int INDEX_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS = 32 - icache_pkg::OFFSET_BITS - INDEX_BITS;

    // read side, from lookup
    logic [INDEX_BITS-1:0] rd_index;
    logic [TAG_BITS-1:0]   cmp_tag;

    // write side, from the controller
    logic                  wr_en;
    logic [INDEX_BITS-1:0] wr_index;
    logic                  wr_valid;
    logic [TAG_BITS-1:0]   wr_tag;
    icache_pkg::line_t     wr_line;

    // way results
    logic                  hit;
    icache_pkg::line_t     rd_line;

    modport lookup (
        output rd_index,
        output cmp_tag
    );

    modport ctrl (
        output wr_en,
        output wr_index,
        output wr_valid,
        output wr_tag,
        output wr_line,
        input  hit,
        input  rd_line
    );

    modport way (
        input  rd_index,
        input  cmp_tag,
        input  wr_en,
        input  wr_index,
        input  wr_valid,
        input  wr_tag,
        input  wr_line,
        output hit,
        output rd_line
    );

endinterface

// ==== tb/icache_tb_tasks.svh ====
task automatic cold_fetch();
    int                reads;
    icache_pkg::word_t word;
    reads = mem_reads;
    fetch_word("cold_fetch", 32'h0000_1124, 1'b0, word);
    check_equal("cold_fetch miss count", reads + 1, mem_reads);
    check_equal("cold_fetch line address", 32'h0000_1120, last_mem_addr);
    check_equal("cold_fetch word", model_word(32'h0000_1124), word);
    fetch_word("cold_fetch", 32'h0000_1138, 1'b0, word);
    check_equal("cold_fetch hit count", reads + 1, mem_reads);
    check_equal("cold_fetch hit word", model_word(32'h0000_1138), word);
endtask

// three lines that all map to set 2
task automatic lru_replacement();
    int                reads;
    icache_pkg::word_t word;
    reads = mem_reads;
    fetch_word("lru_replacement", 32'h0001_0044, 1'b0, word);
    fetch_word("lru_replacement", 32'h0002_0048, 1'b0, word);
    fetch_word("lru_replacement", 32'h0001_0044, 1'b0, word);
    check_equal("lru_replacement fill count", reads + 2, mem_reads);
    fetch_word("lru_replacement", 32'h0003_004c, 1'b0, word);
    check_equal("lru_replacement refill count", reads + 3, mem_reads);
    check_equal("lru_replacement line c word", model_word(32'h0003_004c), word);
    fetch_word("lru_replacement", 32'h0001_0044, 1'b0, word);
    check_equal("lru_replacement a still cached", reads + 3, mem_reads);
    check_equal("lru_replacement a word", model_word(32'h0001_0044), word);
    fetch_word("lru_replacement", 32'h0002_0048, 1'b0, word);
    check_equal("lru_replacement b evicted", reads + 4, mem_reads);
endtask

task automatic uncached_fetch();
    int                reads;
    icache_pkg::word_t word;
    reads = mem_reads;
    fetch_word("uncached_fetch", 32'h0000_2264, 1'b1, word);
    check_equal("uncached_fetch no line read", reads, mem_reads);
    check_equal("uncached_fetch address", 32'h0000_2264, last_uc_addr);
    check_equal("uncached_fetch word", ~32'h0000_2264, word);
    fetch_word("uncached_fetch", 32'h0000_2264, 1'b0, word);
    check_equal("uncached_fetch later miss", reads + 1, mem_reads);
    check_equal("uncached_fetch cached word", model_word(32'h0000_2264), word);
endtask

task automatic invalidate_set();
    int                reads;
    icache_pkg::word_t word;
    reads = mem_reads;
    fetch_word("invalidate_set", 32'h0000_3388, 1'b0, word);
    fetch_word("invalidate_set", 32'h0000_3388, 1'b0, word);
    check_equal("invalidate_set filled", reads + 1, mem_reads);
    wait_idle("busy_o low before cacop");
    cacop_i = 1'b1;
    cacop_addr_i = 32'h0000_3388;
    @(negedge clk);
    cacop_i = 1'b0;
    fetch_word("invalidate_set", 32'h0000_3388, 1'b0, word);
    check_equal("invalidate_set miss after cacop", reads + 2, mem_reads);
    check_equal("invalidate_set word", model_word(32'h0000_3388), word);
endtask

task automatic flush_miss();
    int                reads;
    int                n;
    icache_pkg::word_t word;
    reads = mem_reads;
    wait_idle("busy_o low before the flushed fetch");
    fetch_valid_i = 1'b1;
    fetch_pc_i = 32'h0000_44a8;
    @(negedge clk);
    fetch_valid_i = 1'b0;
    n = 0;
    while (!mem_rd_req_o) begin
        if (n == TIMEOUT) report_timeout("mem_rd_req_o for the flushed fetch");
        n++;
        @(negedge clk);
    end
    flush_i = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
    n = 0;
    while (busy_o) begin
        check_equal("flush_miss delivery suppressed", 0, inst_valid_o);
        if (n == TIMEOUT) report_timeout("busy_o low after the flushed refill");
        n++;
        @(negedge clk);
    end
    check_equal("flush_miss delivery suppressed", 0, inst_valid_o);
    fetch_word("flush_miss", 32'h0000_44a8, 1'b0, word);
    check_equal("flush_miss refill kept", reads + 1, mem_reads);
    check_equal("flush_miss word", model_word(32'h0000_44a8), word);
endtask

// one fetch per cycle, two in flight
task automatic streaming_hits();
    int                reads;
    int                sent;
    int                got;
    int                n;
    icache_pkg::word_t word;
    fetch_word("streaming_hits", 32'h0000_55c4, 1'b0, word);
    reads = mem_reads;
    wait_idle("busy_o low before streaming");
    sent = 0;
    got = 0;
    n = 0;
    while (got < 8) begin
        if (inst_valid_o) begin
            check_equal("streaming_hits word", model_word(32'h0000_55c0 + 32'(4*got)), inst_o);
            got++;
        end
        if (sent < 8) begin
            check_equal("streaming_hits busy", 0, busy_o);
            fetch_valid_i = 1'b1;
            fetch_pc_i = 32'h0000_55c0 + 32'(4*sent);
            sent++;
        end else begin
            fetch_valid_i = 1'b0;
        end
        if (n == TIMEOUT) report_timeout("all eight streamed words");
        n++;
        @(negedge clk);
    end
    fetch_valid_i = 1'b0;
    check_equal("streaming_hits no line read", reads, mem_reads);
endtask

// ==== tb/icache_tb.sv ====
module icache_tb;

    localparam int TIMEOUT = 1000;
    localparam logic [31:0] MEM_XOR = 32'h5a3c_96e1;

    logic              clk;
    logic              reset;
    logic              fetch_valid_i;
    icache_pkg::addr_t fetch_pc_i;
    logic              fetch_uncache_i;
    logic              flush_i;
    logic              cacop_i;
    icache_pkg::addr_t cacop_addr_i;
    logic              busy_o;
    logic              inst_valid_o;
    icache_pkg::word_t inst_o;
    icache_pkg::addr_t inst_pc_o;
    logic              mem_rd_req_o;
    icache_pkg::addr_t mem_rd_addr_o;
    logic              mem_ret_valid_i;
    icache_pkg::line_t mem_ret_data_i;
    logic              uc_ren_o;
    icache_pkg::addr_t uc_addr_o;
    logic              uc_rvalid_i;
    icache_pkg::word_t uc_rdata_i;

    int                mem_reads;
    icache_pkg::addr_t last_mem_addr;
    icache_pkg::addr_t last_uc_addr;

    icache_top DUT (
        .clk             (clk),
        .reset           (reset),
        .fetch_valid_i   (fetch_valid_i),
        .fetch_pc_i      (fetch_pc_i),
        .fetch_uncache_i (fetch_uncache_i),
        .flush_i         (flush_i),
        .cacop_i         (cacop_i),
        .cacop_addr_i    (cacop_addr_i),
        .busy_o          (busy_o),
        .inst_valid_o    (inst_valid_o),
        .inst_o          (inst_o),
        .inst_pc_o       (inst_pc_o),
        .mem_rd_req_o    (mem_rd_req_o),
        .mem_rd_addr_o   (mem_rd_addr_o),
        .mem_ret_valid_i (mem_ret_valid_i),
        .mem_ret_data_i  (mem_ret_data_i),
        .uc_ren_o        (uc_ren_o),
        .uc_addr_o       (uc_addr_o),
        .uc_rvalid_i     (uc_rvalid_i),
        .uc_rdata_i      (uc_rdata_i)
    );

    always #50 clk = ~clk;

    // word k of a line is its address plus 4k, scrambled
    function automatic icache_pkg::line_t model_line(icache_pkg::addr_t line_addr);
        icache_pkg::line_t line;
        for (int k = 0; k < icache_pkg::WORDS_PER_LINE; k++) begin
            line[32*k +: 32] = (line_addr + 32'(4*k)) ^ MEM_XOR;
        end
        return line;
    endfunction

    function automatic icache_pkg::word_t model_word(icache_pkg::addr_t pc);
        icache_pkg::addr_t base;
        base = pc & ~32'h1f;
        return (base + {27'd0, pc[4:2], 2'b00}) ^ MEM_XOR;
    endfunction

    task automatic check_equal(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic report_timeout(string what);
        $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped on a timeout");
    endtask

    task automatic wait_idle(string what);
        int n;
        n = 0;
        while (busy_o) begin
            if (n == TIMEOUT) report_timeout(what);
            n++;
            @(negedge clk);
        end
    endtask

    task automatic wait_inst(string what);
        int n;
        n = 0;
        while (!inst_valid_o) begin
            if (n == TIMEOUT) report_timeout(what);
            n++;
            @(negedge clk);
        end
    endtask

    task automatic fetch_word(
        input  string             name,
        input  icache_pkg::addr_t pc,
        input  logic              uncache,
        output icache_pkg::word_t word
    );
        wait_idle("busy_o low before a fetch");
        fetch_valid_i = 1'b1;
        fetch_pc_i = pc;
        fetch_uncache_i = uncache;
        @(negedge clk);
        fetch_valid_i = 1'b0;
        fetch_uncache_i = 1'b0;
        wait_inst("inst_valid_o after a fetch");
        check_equal({name, " pc"}, pc, inst_pc_o);
        word = inst_o;
        @(negedge clk);
    endtask

    `include "icache_tb_tasks.svh"

    always @(negedge clk) begin
        if (mem_rd_req_o) begin
            mem_reads++;
        end
    end

    // line memory, random return latency
    always @(negedge clk) begin
        icache_pkg::addr_t line_addr;
        int unsigned       lat;
        if (mem_rd_req_o) begin
            line_addr = mem_rd_addr_o;
            last_mem_addr = line_addr;
            lat = $urandom % 4;
            repeat (lat) @(negedge clk);
            mem_ret_data_i = model_line(line_addr);
            mem_ret_valid_i = 1'b1;
            @(negedge clk);
            mem_ret_valid_i = 1'b0;
        end
    end

    // uncached port answers with the inverted address
    always @(negedge clk) begin
        int unsigned lat;
        if (uc_ren_o) begin
            last_uc_addr = uc_addr_o;
            lat = $urandom % 4;
            repeat (lat) @(negedge clk);
            uc_rdata_i = ~last_uc_addr;
            uc_rvalid_i = 1'b1;
            @(negedge clk);
            uc_rvalid_i = 1'b0;
        end
    end

    initial begin
        void'($urandom(32'he644_d12d));
        clk = 1'b0;
        reset = 1'b1;
        fetch_valid_i = 1'b0;
        fetch_pc_i = '0;
        fetch_uncache_i = 1'b0;
        flush_i = 1'b0;
        cacop_i = 1'b0;
        cacop_addr_i = '0;
        mem_ret_valid_i = 1'b0;
        mem_ret_data_i = '0;
        uc_rvalid_i = 1'b0;
        uc_rdata_i = '0;
        mem_reads = 0;
        last_mem_addr = '0;
        last_uc_addr = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        cold_fetch();
        lru_replacement();
        uncached_fetch();
        invalidate_set();
        flush_miss();
        streaming_hits();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+tb
src/icache_pkg.sv
src/icache_way_if.sv
src/icache_sdp_ram.sv
src/icache_way.sv
src/icache_lookup.sv
src/icache_refill_ctrl.sv
src/icache_top.sv
tb/icache_tb.sv
